// File: bus_defines.svh
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// widths of the read address and read data buses.
`define BUS_AW 32
`define BUS_DW 32

// ##########################################################
// address map
// ##########################################################

// the timer window is 64 KiB, matched on the upper 16 address bits.
`define CLINT_BASE 32'h0200_0000
`define CLINT_MASK 32'hFFFF_0000

// the memory window covers MEM_WORDS words, so the mask spans 128 bytes.
`define MEM_BASE   32'h8000_0000
`define MEM_MASK   32'hFFFF_FF80
`define MEM_WORDS  32

// memory address acceptance to rvalid takes at least 1 cycle.
`define MEM_LATENCY 2

`endif

// File: axi_read_pkg.sv
`include "bus_defines.svh"

package axi_read_pkg;

  // ##########################################################
  // read channel payloads
  // ##########################################################

  // the two AXI response codes that this bus produces.
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } axi_resp_e;

  // read address channel payload.
  // Length and ID travel along but are always zero here.
  typedef struct packed {
    logic [`BUS_AW-1:0] araddr;
    logic [2:0]         arsize;
    logic [7:0]         arlen;
    logic [3:0]         arid;
  } axi_ar_t;

  // read data channel payload.
  typedef struct packed {
    logic [`BUS_DW-1:0] rdata;
    axi_resp_e          rresp;
  } axi_r_t;

endpackage

// File: soc_map_pkg.sv
package soc_map_pkg;

  // target chosen by the address decode of the crossbar.
  typedef enum logic [1:0] {
    TGT_NONE  = 2'd0,
    TGT_MEM   = 2'd1,
    TGT_CLINT = 2'd2
  } target_e;

  // ##########################################################
  // timer register offsets within the 64 KiB window
  // ##########################################################

  localparam int CLINT_OFS_W = 16;

  // low and high words of the machine time counter.
  localparam logic [CLINT_OFS_W-1:0] MTIME_LO_OFS = 16'hBFF8;
  localparam logic [CLINT_OFS_W-1:0] MTIME_HI_OFS = 16'hBFFC;

endpackage

// File: axi_read_xbar.sv
`timescale 1ns/1ps
`include "bus_defines.svh"

module axi_read_xbar (
  input  logic                  clk,
  input  logic                  rstn,
  // upstream port
  input  axi_read_pkg::axi_ar_t up_ar,
  input  logic                  up_arvalid,
  output logic                  up_arready,
  output axi_read_pkg::axi_r_t  up_r,
  output logic                  up_rvalid,
  input  logic                  up_rready,
  // memory target
  output axi_read_pkg::axi_ar_t mem_ar,
  output logic                  mem_arvalid,
  input  logic                  mem_arready,
  input  axi_read_pkg::axi_r_t  mem_r,
  input  logic                  mem_rvalid,
  output logic                  mem_rready,
  // timer target
  output axi_read_pkg::axi_ar_t clint_ar,
  output logic                  clint_arvalid,
  input  logic                  clint_arready,
  input  axi_read_pkg::axi_r_t  clint_r,
  input  logic                  clint_rvalid,
  output logic                  clint_rready
);
  import axi_read_pkg::*;
  import soc_map_pkg::*;

  logic    idle;
  target_e dec_tgt;
  target_e sel;
  axi_ar_t fwd_ar;
  logic    ar_hs;
  logic    r_hs;

  // ##########################################################
  // address decode and AR routing
  // ##########################################################

  always_comb begin
    if ((up_ar.araddr & `MEM_MASK) == `MEM_BASE) begin
      dec_tgt = TGT_MEM;
    end else if ((up_ar.araddr & `CLINT_MASK) == `CLINT_BASE) begin
      dec_tgt = TGT_CLINT;
    end else begin
      dec_tgt = TGT_NONE;
    end
  end

  // only single beats with ID zero go downstream.
  always_comb begin
    fwd_ar       = up_ar;
    fwd_ar.arlen = '0;
    fwd_ar.arid  = '0;
  end

  assign mem_ar   = fwd_ar;
  assign clint_ar = fwd_ar;

  assign mem_arvalid   = idle && up_arvalid && (dec_tgt == TGT_MEM);
  assign clint_arvalid = idle && up_arvalid && (dec_tgt == TGT_CLINT);

  // an unmapped address is taken at once and answered here.
  always_comb begin
    case (dec_tgt)
      TGT_MEM:   up_arready = idle && mem_arready;
      TGT_CLINT: up_arready = idle && clint_arready;
      default:   up_arready = idle;
    endcase
  end

  assign ar_hs = up_arvalid && up_arready;
  assign r_hs  = up_rvalid && up_rready;

  // one read in flight. The target is held until its beat is taken.
  always_ff @(posedge clk) begin
    if (rstn) begin
      idle <= 1'b1;
      sel  <= TGT_NONE;
    end else if (ar_hs) begin
      idle <= 1'b0;
      sel  <= dec_tgt;
    end else if (r_hs) begin
      idle <= 1'b1;
    end
  end

  // ##########################################################
  // R routing and decode-error beat
  // ##########################################################

  always_comb begin
    up_r.rdata   = '0;
    up_r.rresp   = OKAY;
    up_rvalid    = 1'b0;
    mem_rready   = 1'b0;
    clint_rready = 1'b0;
    if (!idle) begin
      case (sel)
        TGT_MEM: begin
          up_r       = mem_r;
          up_rvalid  = mem_rvalid;
          mem_rready = up_rready;
        end
        TGT_CLINT: begin
          up_r         = clint_r;
          up_rvalid    = clint_rvalid;
          clint_rready = up_rready;
        end
        default: begin
          // the error beat is ready the cycle after acceptance.
          up_r.rresp = DECERR;
          up_rvalid  = 1'b1;
        end
      endcase
    end
  end

endmodule

// File: sram_read_target.sv
`timescale 1ns/1ps
`include "bus_defines.svh"

module sram_read_target (
  input  logic                  clk,
  input  logic                  rstn,
  input  axi_read_pkg::axi_ar_t ar,
  input  logic                  arvalid,
  output logic                  arready,
  output axi_read_pkg::axi_r_t  r,
  output logic                  rvalid,
  input  logic                  rready
);
  import axi_read_pkg::*;

  localparam int IDX_W = $clog2(`MEM_WORDS);
  localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

  logic [`BUS_DW-1:0] rom [`MEM_WORDS];
  logic [IDX_W-1:0]   ar_idx;
  logic [IDX_W-1:0]   idx_q;
  logic [CNT_W-1:0]   wait_cnt;
  logic [`BUS_DW-1:0] rdata_q;
  logic               rvalid_q;
  logic               ar_hs;
  logic               fire;

  initial begin
    $readmemh("mem_init.hex", rom);
  end

  // word index within the window.
  assign ar_idx = ar.araddr[IDX_W+1:2];

  assign arready = (wait_cnt == '0) && !rvalid_q;
  assign ar_hs   = arvalid && arready;

  // the response slot is loaded on the last cycle of the countdown.
  assign fire = (`MEM_LATENCY == 1) ? ar_hs : (wait_cnt == CNT_W'(1));

  // ##########################################################
  // latency countdown and response hold
  // ##########################################################

  always_ff @(posedge clk) begin
    if (rstn) begin
      wait_cnt <= '0;
      rvalid_q <= 1'b0;
    end else begin
      if (ar_hs && (`MEM_LATENCY > 1)) begin
        wait_cnt <= CNT_W'(`MEM_LATENCY - 1);
      end else if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      if (fire) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      idx_q <= ar_idx;
    end
    if (fire) begin
      rdata_q <= rom[(`MEM_LATENCY == 1) ? ar_idx : idx_q];
    end
  end

  assign r.rdata = rdata_q;
  assign r.rresp = OKAY;
  assign rvalid  = rvalid_q;

endmodule

// File: clint_timer.sv
`timescale 1ns/1ps
`include "bus_defines.svh"

module clint_timer (
  input  logic                  clk,
  input  logic                  rstn,
  input  axi_read_pkg::axi_ar_t ar,
  input  logic                  arvalid,
  output logic                  arready,
  output axi_read_pkg::axi_r_t  r,
  output logic                  rvalid,
  input  logic                  rready
);
  import axi_read_pkg::*;
  import soc_map_pkg::*;

  logic [63:0]            mtime;
  logic [CLINT_OFS_W-1:0] ofs;
  logic [`BUS_DW-1:0]     rd_word;
  logic [`BUS_DW-1:0]     rdata_q;
  logic                   rvalid_q;
  logic                   ar_hs;

  // free-running machine time is zero in the first cycle out of reset.
  always_ff @(posedge clk) begin
    if (rstn) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // ##########################################################
  // register read
  // ##########################################################

  assign ofs     = ar.araddr[CLINT_OFS_W-1:0];
  assign arready = !rvalid_q;
  assign ar_hs   = arvalid && arready;

  // unknown offsets read as zero.
  always_comb begin
    case (ofs)
      MTIME_LO_OFS: rd_word = mtime[31:0];
      MTIME_HI_OFS: rd_word = mtime[63:32];
      default:      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      rvalid_q <= 1'b0;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
    end else if (rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // the word is captured at acceptance and held while stalled.
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata_q <= rd_word;
    end
  end

  assign r.rdata = rdata_q;
  assign r.rresp = OKAY;
  assign rvalid  = rvalid_q;

endmodule

// File: read_subsystem_top.sv
`timescale 1ns/1ps

module read_subsystem_top (
  input  logic                  clk,
  input  logic                  rstn,
  input  axi_read_pkg::axi_ar_t up_ar,
  input  logic                  up_arvalid,
  output logic                  up_arready,
  output axi_read_pkg::axi_r_t  up_r,
  output logic                  up_rvalid,
  input  logic                  up_rready
);
  import axi_read_pkg::*;

  axi_ar_t mem_ar;
  logic    mem_arvalid;
  logic    mem_arready;
  axi_r_t  mem_r;
  logic    mem_rvalid;
  logic    mem_rready;

  axi_ar_t clint_ar;
  logic    clint_arvalid;
  logic    clint_arready;
  axi_r_t  clint_r;
  logic    clint_rvalid;
  logic    clint_rready;

  axi_read_xbar i_axi_read_xbar (
    .clk           (clk),
    .rstn          (rstn),
    .up_ar         (up_ar),
    .up_arvalid    (up_arvalid),
    .up_arready    (up_arready),
    .up_r          (up_r),
    .up_rvalid     (up_rvalid),
    .up_rready     (up_rready),
    .mem_ar        (mem_ar),
    .mem_arvalid   (mem_arvalid),
    .mem_arready   (mem_arready),
    .mem_r         (mem_r),
    .mem_rvalid    (mem_rvalid),
    .mem_rready    (mem_rready),
    .clint_ar      (clint_ar),
    .clint_arvalid (clint_arvalid),
    .clint_arready (clint_arready),
    .clint_r       (clint_r),
    .clint_rvalid  (clint_rvalid),
    .clint_rready  (clint_rready)
  );

  sram_read_target i_sram_read_target (
    .clk     (clk),
    .rstn    (rstn),
    .ar      (mem_ar),
    .arvalid (mem_arvalid),
    .arready (mem_arready),
    .r       (mem_r),
    .rvalid  (mem_rvalid),
    .rready  (mem_rready)
  );

  clint_timer i_clint_timer (
    .clk     (clk),
    .rstn    (rstn),
    .ar      (clint_ar),
    .arvalid (clint_arvalid),
    .arready (clint_arready),
    .r       (clint_r),
    .rvalid  (clint_rvalid),
    .rready  (clint_rready)
  );

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps
`include "bus_defines.svh"

module tb_checker (
  input  logic                  clk,
  input  logic                  rstn,
  input  axi_read_pkg::axi_ar_t up_ar,
  input  logic                  up_arvalid,
  input  logic                  up_arready,
  input  axi_read_pkg::axi_r_t  up_r,
  input  logic                  up_rvalid,
  input  logic                  up_rready,
  input  logic                  done,
  output int                    error_count
);
  import axi_read_pkg::*;
  import soc_map_pkg::*;

  localparam int IDX_W = $clog2(`MEM_WORDS);

  logic [`BUS_DW-1:0] mem_model [`MEM_WORDS];
  logic [63:0]        cycle_count;
  logic [`BUS_AW-1:0] exp_addr;
  logic [IDX_W-1:0]   idx;
  target_e            tgt;
  axi_r_t             exp_r;
  axi_r_t             held_r;
  logic               inflight;
  logic               held;
  logic               seen_rvalid;
  logic               rst_q = 1'b0;
  logic               summary_done = 1'b0;
  int                 exp_lat;
  int                 wait_cycles;
  int                 read_count = 0;
  int                 beat_count = 0;
  int                 errors = 0;

  assign error_count = errors;

  initial begin
    $readmemh("mem_init.hex", mem_model);
  end

  task automatic log_error(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic log_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // target of an address by the SoC memory map.
  function automatic target_e decode_target(input logic [`BUS_AW-1:0] addr);
    if (addr >= `MEM_BASE && addr < `MEM_BASE + 4 * `MEM_WORDS) begin
      return TGT_MEM;
    end
    if (addr >= `CLINT_BASE && addr < `CLINT_BASE + 32'h0001_0000) begin
      return TGT_CLINT;
    end
    return TGT_NONE;
  endfunction

  // ##########################################################
  // cycle model of the upstream port
  // ##########################################################

  always @(posedge clk) begin
    if (rst_q && up_rvalid !== 1'b0) begin
      log_error("up_rvalid is high during or right after reset");
    end
    rst_q = rstn;
    if (rstn) begin
      cycle_count = '0;
      inflight    = 1'b0;
      held        = 1'b0;
      seen_rvalid = 1'b0;
    end else begin
      // a stalled beat must stay put until it is taken.
      if (held) begin
        if (up_rvalid !== 1'b1) begin
          log_error("up_rvalid dropped while up_rready was low");
        end else if (up_r !== held_r) begin
          log_error($sformatf("up_r changed from %h to %h under stall", held_r, up_r));
        end
      end
      if (inflight && !seen_rvalid) begin
        wait_cycles++;
        if (up_rvalid === 1'b1) begin
          seen_rvalid = 1'b1;
          if (wait_cycles != exp_lat) begin
            log_error($sformatf("read of %h answered after %0d cycles, expected %0d",
                                exp_addr, wait_cycles, exp_lat));
          end
        end
      end
      if (!inflight && up_rvalid !== 1'b0) begin
        log_error("up_rvalid is high with no read in flight");
      end
      if (inflight && up_arready !== 1'b0) begin
        log_error("up_arready is high while a read is in flight");
      end
      if (inflight && up_rvalid === 1'b1 && up_rready === 1'b1) begin
        beat_count++;
        inflight = 1'b0;
        if (up_r !== exp_r) begin
          log_error($sformatf("read of %h returned data %h resp %0d, expected %h resp %0d",
                              exp_addr, up_r.rdata, up_r.rresp, exp_r.rdata, exp_r.rresp));
        end
      end
      held   = inflight && up_rvalid === 1'b1 && up_rready !== 1'b1;
      held_r = up_r;
      if (up_arvalid === 1'b1 && up_arready === 1'b1) begin
        read_count++;
        exp_addr    = up_ar.araddr;
        tgt         = decode_target(exp_addr);
        exp_r.rdata = '0;
        exp_r.rresp = OKAY;
        exp_lat     = 1;
        case (tgt)
          TGT_MEM: begin
            idx         = IDX_W'((exp_addr - `MEM_BASE) >> 2);
            exp_r.rdata = mem_model[idx];
            exp_lat     = `MEM_LATENCY;
          end
          TGT_CLINT: begin
            // the timer answers with mtime as it stood at acceptance.
            if (exp_addr == `CLINT_BASE + 32'(MTIME_LO_OFS)) begin
              exp_r.rdata = cycle_count[31:0];
            end else if (exp_addr == `CLINT_BASE + 32'(MTIME_HI_OFS)) begin
              exp_r.rdata = cycle_count[63:32];
            end
          end
          default: exp_r.rresp = DECERR;
        endcase
        inflight    = 1'b1;
        seen_rvalid = 1'b0;
        wait_cycles = 0;
      end
      cycle_count = cycle_count + 64'd1;
    end
    if (done && !summary_done) begin
      summary_done = 1'b1;
      if (inflight || read_count != beat_count) begin
        log_failure("a read was accepted but its response never came back");
      end
      $display("checker: %0d reads, %0d beats, %0d errors", read_count, beat_count, errors);
    end
  end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps
`include "bus_defines.svh"

module tb_top;
  import axi_read_pkg::*;
  import soc_map_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_READS    = 400;
  localparam int GAP_MAX      = 7;
  localparam int STALL_MAX    = 7;
  // gap, address beat, latency, stall and a little slack per read.
  localparam int READ_CYCLES  = GAP_MAX + 1 + `MEM_LATENCY + STALL_MAX + 3;
  localparam int WATCHDOG_NS  = (NUM_READS * READ_CYCLES + RESET_CYCLES + 50) * CLK_PERIOD;

  logic        clk;
  logic        rstn;
  axi_ar_t     up_ar;
  logic        up_arvalid;
  logic        up_arready;
  axi_r_t      up_r;
  logic        up_rvalid;
  logic        up_rready;
  logic        stim_done;
  int          error_count;
  logic [31:0] lfsr_state;

  read_subsystem_top i_read_subsystem_top (
    .clk        (clk),
    .rstn       (rstn),
    .up_ar      (up_ar),
    .up_arvalid (up_arvalid),
    .up_arready (up_arready),
    .up_r       (up_r),
    .up_rvalid  (up_rvalid),
    .up_rready  (up_rready)
  );

  tb_checker i_tb_checker (
    .clk         (clk),
    .rstn        (rstn),
    .up_ar       (up_ar),
    .up_arvalid  (up_arvalid),
    .up_arready  (up_arready),
    .up_r        (up_r),
    .up_rvalid   (up_rvalid),
    .up_rready   (up_rready),
    .done        (stim_done),
    .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Galois LFSR that takes one step per bit handed out.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'hD000_0001;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return val;
  endfunction

  // ##########################################################
  // stimulus
  // ##########################################################

  function automatic logic [31:0] pick_address();
    logic [2:0] cls;
    cls = 3'(rand_bits(3));
    case (cls)
      3'd0, 3'd1, 3'd2: return `MEM_BASE + (rand_bits(5) << 2);
      3'd3:             return `CLINT_BASE + {16'h0, MTIME_LO_OFS};
      3'd4:             return `CLINT_BASE + {16'h0, MTIME_HI_OFS};
      3'd5:             return `CLINT_BASE + (rand_bits(12) << 2);
      // just past the end of the memory window.
      3'd6:             return `MEM_BASE + 32'h80 + (rand_bits(5) << 2);
      default:          return 32'h1000_0000 | (rand_bits(16) << 2);
    endcase
  endfunction

  task automatic do_read(input logic [31:0] addr, input int gap, input int stall);
    logic taken;
    logic seen;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    up_ar        = '0;
    up_ar.araddr = addr;
    up_ar.arsize = 3'd2;
    up_arvalid   = 1'b1;
    do begin
      @(negedge clk);
      taken = up_arready;
      @(posedge clk);
    end while (!taken);
    #1;
    up_arvalid = 1'b0;
    up_ar      = '0;
    up_rready  = (stall == 0);
    do begin
      @(negedge clk);
      seen = up_rvalid;
      @(posedge clk);
    end while (!seen);
    if (stall > 0) begin
      repeat (stall - 1) @(posedge clk);
      #1;
      up_rready = 1'b1;
      @(posedge clk);
    end
    #1;
    up_rready = 1'b0;
  endtask

  initial begin
    logic [31:0] addr;
    int          gap;
    int          stall;
    lfsr_state = 32'hd48e;
    rstn       = 1'b1;
    up_ar      = '0;
    up_arvalid = 1'b0;
    up_rready  = 1'b0;
    stim_done  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstn = 1'b0;
    for (int i = 0; i < NUM_READS; i++) begin
      addr  = pick_address();
      gap   = int'(rand_bits(3));
      stall = int'(rand_bits(3));
      do_read(addr, gap, stall);
    end
    stim_done = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: the run timed out before all reads were answered");
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: mem_init.hex
// one 32-bit word per line, in hex, for word index 0 to 31 of the memory window.
00000013
00a00093
01400113
00208193
40110233
0041a2b3
00524333
0062e3b3
00737433
00141493
0014d513
4014d593
fff00613
0c800693
deadbeef
cafef00d
12345678
9abcdef0
0f1e2d3c
4b5a6978
87a5c3e1
f00dface
0badc0de
a5a5a5a5
5a5a5a5a
13579bdf
2468ace0
80000000
7fffffff
00000001
fedcba98
76543210

// File: tb.f
+incdir+.
axi_read_pkg.sv
soc_map_pkg.sv
axi_read_xbar.sv
sram_read_target.sv
clint_timer.sv
read_subsystem_top.sv
tb_checker.sv
tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_top
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
